//--- common/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// core port widths
`define PERIPH_ADDR_WIDTH 32
`define PERIPH_DATA_WIDTH 32
`define PERIPH_BE_WIDTH   4   // one enable per data byte

// bits [19:14] select the peripheral region
`define PERIPH_REGION 6'd1

// bits [13:10] select the slave inside the region
`define EU_TARGET  4'd0
`define DMA_TARGET 4'd1

// event lines into the event unit
`define NUM_EVENTS 8

`endif

//--- common/periph_pkg.sv
`include "periph_config.svh"

package periph_pkg;

  // request phase held by the core until granted
  typedef struct packed {
    logic                            req;
    logic [`PERIPH_ADDR_WIDTH-1:0]   addr;
    logic                            wen;   // low for a write
    logic [`PERIPH_DATA_WIDTH-1:0]   wdata;
    logic [`PERIPH_BE_WIDTH-1:0]     be;
  } periph_req_t;

  // response phase one cycle after the grant
  typedef struct packed {
    logic                            r_valid;
    logic [`PERIPH_DATA_WIDTH-1:0]   r_rdata;
    logic                            r_opc;
  } periph_rsp_t;

  // field view of a peripheral address
  typedef struct packed {
    logic [`PERIPH_ADDR_WIDTH-21:0]  upper;
    logic [5:0]                      region;
    logic [3:0]                      target;
    logic [7:0]                      reg_idx;
    logic [1:0]                      byte_off;
  } periph_addr_t;

  typedef enum logic [1:0] {
    DEST_DMA  = 2'd0,
    DEST_EU   = 2'd1,
    DEST_NONE = 2'd2
  } periph_dest_e;

  // transfer descriptor handed to the DMA engine
  typedef struct packed {
    logic [`PERIPH_ADDR_WIDTH-1:0]   src;
    logic [`PERIPH_ADDR_WIDTH-1:0]   dst;
    logic [15:0]                     len;
  } dma_desc_t;

  // replace the bytes of old_val whose enable is set
  function automatic logic [`PERIPH_DATA_WIDTH-1:0] be_merge(
    input logic [`PERIPH_DATA_WIDTH-1:0] old_val,
    input logic [`PERIPH_DATA_WIDTH-1:0] new_val,
    input logic [`PERIPH_BE_WIDTH-1:0]   be
  );
    logic [`PERIPH_DATA_WIDTH-1:0] res;
    res = old_val;
    for (int b = 0; b < `PERIPH_BE_WIDTH; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

endpackage

//--- periph_demux/periph_demux.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module periph_demux (
  input  logic                   clk,
  input  logic                   rst_ni,

  // core side
  input  periph_pkg::periph_req_t core_req_i,
  output logic                   core_gnt_o,
  output periph_pkg::periph_rsp_t core_rsp_o,

  // event unit side
  output periph_pkg::periph_req_t eu_req_o,
  input  logic                   eu_gnt_i,
  input  periph_pkg::periph_rsp_t eu_rsp_i,

  // dma configuration side
  output periph_pkg::periph_req_t dma_req_o,
  input  logic                   dma_gnt_i,
  input  periph_pkg::periph_rsp_t dma_rsp_i
);

  periph_pkg::periph_addr_t addr_fields;
  periph_pkg::periph_dest_e dest_sel;   // decoded from the current address
  periph_pkg::periph_dest_e dest_q;     // slave owning the pending response
  logic                     region_hit;

  assign addr_fields = core_req_i.addr;
  assign region_hit  = (addr_fields.region == `PERIPH_REGION);

  // target decode inside the peripheral region
  always_comb begin
    dest_sel = periph_pkg::DEST_NONE;
    if (addr_fields.target == `EU_TARGET) begin
      dest_sel = periph_pkg::DEST_EU;
    end else if (addr_fields.target == `DMA_TARGET) begin
      dest_sel = periph_pkg::DEST_DMA;
    end
  end

  // remember who answers next cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      dest_q <= periph_pkg::DEST_DMA;
    end else if (core_req_i.req && region_hit) begin
      dest_q <= dest_sel;   // outside the region the old value stays
    end
  end

  // payload goes to both slaves and only one sees req
  always_comb begin
    eu_req_o       = core_req_i;
    eu_req_o.req   = 1'b0;
    dma_req_o      = core_req_i;
    dma_req_o.req  = 1'b0;
    core_gnt_o     = 1'b0;
    if (region_hit) begin
      case (dest_sel)
        periph_pkg::DEST_EU: begin
          eu_req_o.req = core_req_i.req;
          core_gnt_o   = eu_gnt_i;
        end
        periph_pkg::DEST_DMA: begin
          dma_req_o.req = core_req_i.req;
          core_gnt_o    = dma_gnt_i;
        end
        default: begin
          // an unused target is never granted
          core_gnt_o = 1'b0;
        end
      endcase
    end
  end

  // response return from the recorded slave
  always_comb begin
    case (dest_q)
      periph_pkg::DEST_EU: begin
        core_rsp_o = eu_rsp_i;
      end
      periph_pkg::DEST_DMA: begin
        core_rsp_o = dma_rsp_i;
      end
      default: begin
        core_rsp_o = '0;
      end
    endcase
    core_rsp_o.r_opc = 1'b0;   // no error responses
  end

endmodule

//--- logic/event_unit_regs.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module event_unit_regs (
  input  logic                    clk,
  input  logic                    rst_ni,

  input  periph_pkg::periph_req_t req_i,
  output logic                    gnt_o,
  output periph_pkg::periph_rsp_t rsp_o,

  input  logic [`NUM_EVENTS-1:0]  events_i,
  output logic                    core_sleep_o
);

  localparam logic [7:0] REG_MASK   = 8'd0;
  localparam logic [7:0] REG_BUFFER = 8'd1;
  localparam logic [7:0] REG_CLEAR  = 8'd2;
  localparam logic [7:0] REG_SLEEP  = 8'd3;

  periph_pkg::periph_addr_t      addr;
  periph_pkg::periph_rsp_t       rsp_q;
  logic                          wr_en;
  logic                          rd_en;
  logic [`NUM_EVENTS-1:0]        mask_q;
  logic [`NUM_EVENTS-1:0]        mask_d;
  logic [`NUM_EVENTS-1:0]        buffer_q;
  logic [`NUM_EVENTS-1:0]        buffer_d;
  logic [`NUM_EVENTS-1:0]        clear_bits;
  logic [`PERIPH_DATA_WIDTH-1:0] mask_merged;
  logic [`PERIPH_DATA_WIDTH-1:0] rdata;
  logic                          sleep_q;
  logic                          sleep_d;
  logic                          pending;

  assign addr  = req_i.addr;
  assign gnt_o = req_i.req;   // always ready
  assign wr_en = req_i.req & ~req_i.wen;
  assign rd_en = req_i.req & req_i.wen;

  // mask write honours the byte enables
  assign mask_merged = periph_pkg::be_merge(
    {{(`PERIPH_DATA_WIDTH-`NUM_EVENTS){1'b0}}, mask_q}, req_i.wdata, req_i.be);
  assign mask_d = (wr_en && addr.reg_idx == REG_MASK) ?
                  mask_merged[`NUM_EVENTS-1:0] : mask_q;

  // clear first, then new events, so a same cycle event survives
  assign clear_bits = (wr_en && addr.reg_idx == REG_CLEAR) ?
                      req_i.wdata[`NUM_EVENTS-1:0] : '0;
  assign buffer_d   = (buffer_q & ~clear_bits) | events_i;

  assign pending = |(buffer_q & mask_q);

  // a masked event wakes the core and also blocks a new sleep request
  always_comb begin
    sleep_d = sleep_q;
    if (pending) begin
      sleep_d = 1'b0;
    end else if (wr_en && addr.reg_idx == REG_SLEEP) begin
      sleep_d = 1'b1;
    end
  end

  always_comb begin
    case (addr.reg_idx)
      REG_MASK:   rdata = {{(`PERIPH_DATA_WIDTH-`NUM_EVENTS){1'b0}}, mask_q};
      REG_BUFFER: rdata = {{(`PERIPH_DATA_WIDTH-`NUM_EVENTS){1'b0}}, buffer_q};
      REG_SLEEP:  rdata = {{(`PERIPH_DATA_WIDTH-1){1'b0}}, sleep_q};
      default:    rdata = '0;   // clear is write only
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q   <= '0;
      buffer_q <= '0;
      sleep_q  <= 1'b0;
      rsp_q    <= '0;
    end else begin
      mask_q        <= mask_d;
      buffer_q      <= buffer_d;
      sleep_q       <= sleep_d;
      rsp_q.r_valid <= req_i.req;
      rsp_q.r_rdata <= rd_en ? rdata : '0;   // writes answer with zero
      rsp_q.r_opc   <= 1'b0;
    end
  end

  assign rsp_o        = rsp_q;
  assign core_sleep_o = sleep_q;

endmodule

//--- logic/dma_cfg_regs.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module dma_cfg_regs (
  input  logic                    clk,
  input  logic                    rst_ni,

  input  periph_pkg::periph_req_t req_i,
  output logic                    gnt_o,
  output periph_pkg::periph_rsp_t rsp_o,

  output logic                    dma_start_o,
  output periph_pkg::dma_desc_t   dma_desc_o
);

  localparam logic [7:0] REG_SRC = 8'd0;
  localparam logic [7:0] REG_DST = 8'd1;
  localparam logic [7:0] REG_LEN = 8'd2;
  localparam logic [7:0] REG_CMD = 8'd3;

  periph_pkg::periph_addr_t      addr;
  periph_pkg::periph_rsp_t       rsp_q;
  logic                          wr_en;
  logic                          rd_en;
  logic [`PERIPH_ADDR_WIDTH-1:0] src_q;
  logic [`PERIPH_ADDR_WIDTH-1:0] dst_q;
  logic [15:0]                   len_q;
  logic [`PERIPH_DATA_WIDTH-1:0] len_merged;
  logic [`PERIPH_DATA_WIDTH-1:0] rdata;
  logic                          start_q;

  assign addr  = req_i.addr;
  assign gnt_o = req_i.req;
  assign wr_en = req_i.req & ~req_i.wen;
  assign rd_en = req_i.req & req_i.wen;

  assign len_merged = periph_pkg::be_merge({16'b0, len_q}, req_i.wdata, req_i.be);

  always_comb begin
    case (addr.reg_idx)
      REG_SRC: rdata = src_q;
      REG_DST: rdata = dst_q;
      REG_LEN: rdata = {16'b0, len_q};
      default: rdata = '0;   // command reads as zero
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      start_q <= 1'b0;
      rsp_q   <= '0;
    end else begin
      if (wr_en && addr.reg_idx == REG_SRC) begin
        src_q <= periph_pkg::be_merge(src_q, req_i.wdata, req_i.be);
      end
      if (wr_en && addr.reg_idx == REG_DST) begin
        dst_q <= periph_pkg::be_merge(dst_q, req_i.wdata, req_i.be);
      end
      if (wr_en && addr.reg_idx == REG_LEN) begin
        len_q <= len_merged[15:0];
      end
      start_q       <= wr_en && (addr.reg_idx == REG_CMD);   // single cycle pulse
      rsp_q.r_valid <= req_i.req;
      rsp_q.r_rdata <= rd_en ? rdata : '0;
      rsp_q.r_opc   <= 1'b0;
    end
  end

  assign rsp_o = rsp_q;

  // descriptor follows the registers at all times
  assign dma_desc_o.src = src_q;
  assign dma_desc_o.dst = dst_q;
  assign dma_desc_o.len = len_q;
  assign dma_start_o    = start_q;

endmodule

//--- logic/periph_subsys_top.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module periph_subsys_top (
  input  logic                    clk,
  input  logic                    rst_ni,

  input  periph_pkg::periph_req_t core_req_i,
  output logic                    core_gnt_o,
  output periph_pkg::periph_rsp_t core_rsp_o,

  input  logic [`NUM_EVENTS-1:0]  events_i,
  output logic                    core_sleep_o,

  output logic                    dma_start_o,
  output periph_pkg::dma_desc_t   dma_desc_o
);

  periph_pkg::periph_req_t eu_req;
  periph_pkg::periph_rsp_t eu_rsp;
  logic                    eu_gnt;
  periph_pkg::periph_req_t dma_req;
  periph_pkg::periph_rsp_t dma_rsp;
  logic                    dma_gnt;

  periph_demux i_demux (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .core_req_i (core_req_i),
    .core_gnt_o (core_gnt_o),
    .core_rsp_o (core_rsp_o),
    .eu_req_o   (eu_req),
    .eu_gnt_i   (eu_gnt),
    .eu_rsp_i   (eu_rsp),
    .dma_req_o  (dma_req),
    .dma_gnt_i  (dma_gnt),
    .dma_rsp_i  (dma_rsp)
  );

  event_unit_regs i_event_unit (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .req_i        (eu_req),
    .gnt_o        (eu_gnt),
    .rsp_o        (eu_rsp),
    .events_i     (events_i),
    .core_sleep_o (core_sleep_o)
  );

  dma_cfg_regs i_dma_cfg (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .req_i       (dma_req),
    .gnt_o       (dma_gnt),
    .rsp_o       (dma_rsp),
    .dma_start_o (dma_start_o),
    .dma_desc_o  (dma_desc_o)
  );

endmodule

//--- verif/periph_subsys_tb.sv
`timescale 1ns/10ps
`include "periph_config.svh"

module periph_subsys_tb;

  localparam logic [3:0] OP_READ      = 4'd0;
  localparam logic [3:0] OP_WRITE     = 4'd1;
  localparam logic [3:0] OP_UNMAPPED  = 4'd2;
  localparam logic [3:0] OP_EVENT     = 4'd3;
  localparam logic [7:0] CMD_IDX      = 8'd3;   // dma command register
  localparam int         STALL_CYCLES = 4;

  // one line of the trace file
  typedef struct packed {
    logic [3:0]                    kind;
    logic [`PERIPH_ADDR_WIDTH-1:0] addr;
    logic [`PERIPH_DATA_WIDTH-1:0] wdata;
    logic [`PERIPH_BE_WIDTH-1:0]   be;
    logic [`NUM_EVENTS-1:0]        events;
    logic [`PERIPH_DATA_WIDTH-1:0] rdata;
    logic                          sleep;
    periph_pkg::dma_desc_t         desc;
  } trace_op_t;

  logic                    clk;
  logic                    rst_ni;
  periph_pkg::periph_req_t core_req;
  logic                    core_gnt;
  periph_pkg::periph_rsp_t core_rsp;
  logic [`NUM_EVENTS-1:0]  events;
  logic                    core_sleep;
  logic                    dma_start;
  periph_pkg::dma_desc_t   dma_desc;

  trace_op_t   ops[$];
  int          cycle_cnt = 0;
  int          max_cycles = 20;
  logic [31:0] rng_state;

  periph_subsys_top UUT (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .core_req_i   (core_req),
    .core_gnt_o   (core_gnt),
    .core_rsp_o   (core_rsp),
    .events_i     (events),
    .core_sleep_o (core_sleep),
    .dma_start_o  (dma_start),
    .dma_desc_o   (dma_desc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // the limit is set once the trace length is known
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      report_failure($sformatf("timeout: the run did not finish within %0d cycles", max_cycles));
    end
  end

  task automatic check_rsp(input string name, input periph_pkg::periph_rsp_t exp,
                           input periph_pkg::periph_rsp_t act);
    if (act !== exp) begin
      report_failure($sformatf("[FAIL] %s response: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_desc(input string name, input periph_pkg::dma_desc_t exp,
                            input periph_pkg::dma_desc_t act);
    if (act !== exp) begin
      report_failure($sformatf("[FAIL] %s descriptor: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_sleep(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("[FAIL] %s sleep: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string kind_name(input logic [3:0] kind);
    case (kind)
      OP_READ:     return "read";
      OP_WRITE:    return "write";
      OP_UNMAPPED: return "unmapped";
      OP_EVENT:    return "event";
      default:     return "unknown";
    endcase
  endfunction

  // a write to the command register of the dma slave starts a transfer
  function automatic logic is_dma_cmd(input trace_op_t op);
    periph_pkg::periph_addr_t fields;
    fields = op.addr;
    return (op.kind == OP_WRITE) && (fields.region == `PERIPH_REGION) &&
           (fields.target == `DMA_TARGET) && (fields.reg_idx == CMD_IDX);
  endfunction

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_kind;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_be;
    logic [31:0] f_events;
    logic [31:0] f_rdata;
    logic [31:0] f_sleep;
    logic [31:0] f_src;
    logic [31:0] f_dst;
    logic [31:0] f_len;
    trace_op_t   op;
    fd = $fopen("verif/periph_trace.txt", "r");
    if (fd == 0) begin
      report_failure("could not open the trace file verif/periph_trace.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_kind, f_addr, f_wdata, f_be,
                    f_events, f_rdata, f_sleep, f_src, f_dst, f_len);
        if (n != 10) begin
          report_failure($sformatf("trace line cannot be parsed: %s", line));
        end
        op.kind     = f_kind[3:0];
        op.addr     = f_addr;
        op.wdata    = f_wdata;
        op.be       = f_be[`PERIPH_BE_WIDTH-1:0];
        op.events   = f_events[`NUM_EVENTS-1:0];
        op.rdata    = f_rdata;
        op.sleep    = f_sleep[0];
        op.desc.src = f_src;
        op.desc.dst = f_dst;
        op.desc.len = f_len[15:0];
        ops.push_back(op);
      end
    end
    $fclose(fd);
  endtask

  // load or store through the core port with the response checked one cycle after grant
  task automatic access_core_port(input trace_op_t op, input string name);
    periph_pkg::periph_rsp_t exp_rsp;
    @(posedge clk);
    core_req.req   <= 1'b1;
    core_req.addr  <= op.addr;
    core_req.wen   <= (op.kind == OP_READ);
    core_req.wdata <= op.wdata;
    core_req.be    <= op.be;
    @(negedge clk);
    while (core_gnt !== 1'b1) @(negedge clk);
    check_flag({name, " r_valid before grant"}, 1'b0, core_rsp.r_valid);
    @(posedge clk);   // accepted on this edge
    core_req.req <= 1'b0;
    @(negedge clk);
    exp_rsp.r_valid = 1'b1;
    exp_rsp.r_rdata = op.rdata;
    exp_rsp.r_opc   = 1'b0;
    check_rsp(name, exp_rsp, core_rsp);
    check_sleep(name, op.sleep, core_sleep);
    check_desc(name, op.desc, dma_desc);
    check_flag({name, " dma start"}, is_dma_cmd(op), dma_start);
    @(negedge clk);
    check_flag({name, " r_valid one cycle later"}, 1'b0, core_rsp.r_valid);
    check_flag({name, " dma start one cycle later"}, 1'b0, dma_start);
  endtask

  // request outside the map is never granted and is withdrawn after a while
  task automatic stall_unmapped(input trace_op_t op, input string name);
    @(posedge clk);
    core_req.req   <= 1'b1;
    core_req.addr  <= op.addr;
    core_req.wen   <= 1'b0;
    core_req.wdata <= op.wdata;
    core_req.be    <= op.be;
    repeat (STALL_CYCLES) begin
      @(negedge clk);
      check_flag({name, " grant"}, 1'b0, core_gnt);
      check_flag({name, " r_valid while stalled"}, 1'b0, core_rsp.r_valid);
    end
    @(posedge clk);
    core_req.req <= 1'b0;
    @(negedge clk);
    check_flag({name, " r_valid after withdraw"}, 1'b0, core_rsp.r_valid);
    check_flag({name, " dma start"}, 1'b0, dma_start);
    check_sleep(name, op.sleep, core_sleep);
    check_desc(name, op.desc, dma_desc);
  endtask

  task automatic pulse_events(input trace_op_t op, input string name);
    @(posedge clk);
    events <= op.events;
    @(posedge clk);   // buffer captures the pulse here
    events <= '0;
    @(posedge clk);   // sleep reacts to the buffer here
    @(negedge clk);
    check_sleep(name, op.sleep, core_sleep);
    check_desc(name, op.desc, dma_desc);
  endtask

  task automatic idle_gap();
    int gap;
    rng_state = xorshift32(rng_state);
    gap = int'(rng_state[1:0]);
    repeat (gap) @(posedge clk);
  endtask

  initial begin
    string                   name;
    trace_op_t               op;
    periph_pkg::periph_rsp_t zero_rsp;
    periph_pkg::dma_desc_t   zero_desc;
    rst_ni    <= 1'b0;
    core_req  <= '0;
    events    <= '0;
    rng_state = 32'd99128;
    zero_rsp  = '0;
    zero_desc = '0;
    load_trace();
    if (ops.size() == 0) begin
      report_failure("the trace file holds no operations");
    end
    max_cycles = 10 * ops.size() + 20;
    repeat (3) @(posedge clk);
    rst_ni <= 1'b1;
    @(negedge clk);
    // everything quiet after reset
    check_flag("reset grant", 1'b0, core_gnt);
    check_rsp("reset", zero_rsp, core_rsp);
    check_sleep("reset", 1'b0, core_sleep);
    check_desc("reset", zero_desc, dma_desc);
    check_flag("reset dma start", 1'b0, dma_start);
    foreach (ops[i]) begin
      op   = ops[i];
      name = $sformatf("trace op %0d (%s)", i + 1, kind_name(op.kind));
      case (op.kind)
        OP_READ, OP_WRITE: access_core_port(op, name);
        OP_UNMAPPED:       stall_unmapped(op, name);
        OP_EVENT:          pulse_events(op, name);
        default:           report_failure($sformatf("%s has an unknown kind", name));
      endcase
      idle_gap();
    end
    $display("All checks passed");
    $finish;
  end

endmodule

//--- verif/periph_trace.txt
# kind: 0 read, 1 write, 2 unmapped write (never granted), 3 event pulse; all columns hex
# kind addr wdata be events exp_rdata exp_sleep exp_src exp_dst exp_len
0 00004400 00000000 f 00 00000000 0 00000000 00000000 0000
1 00004400 80001000 f 00 00000000 0 80001000 00000000 0000
0 00004400 00000000 f 00 80001000 0 80001000 00000000 0000
1 00004404 90002000 f 00 00000000 0 80001000 90002000 0000
1 00004404 aabbccdd 3 00 00000000 0 80001000 9000ccdd 0000
0 1a104404 00000000 f 00 9000ccdd 0 80001000 9000ccdd 0000
1 00004408 12340180 f 00 00000000 0 80001000 9000ccdd 0180
1 00004408 00002a00 2 00 00000000 0 80001000 9000ccdd 2a80
0 00004408 00000000 f 00 00002a80 0 80001000 9000ccdd 2a80
1 0000440c 00000001 f 00 00000000 0 80001000 9000ccdd 2a80
0 0000440c 00000000 f 00 00000000 0 80001000 9000ccdd 2a80
3 00000000 00000000 0 05 00000000 0 80001000 9000ccdd 2a80
0 00004004 00000000 f 00 00000005 0 80001000 9000ccdd 2a80
3 00000000 00000000 0 30 00000000 0 80001000 9000ccdd 2a80
1 00004008 00000004 f 00 00000000 0 80001000 9000ccdd 2a80
0 00004004 00000000 f 00 00000031 0 80001000 9000ccdd 2a80
1 00004000 000000c0 f 00 00000000 0 80001000 9000ccdd 2a80
0 00004000 00000000 f 00 000000c0 0 80001000 9000ccdd 2a80
1 0000400c 00000001 f 00 00000000 1 80001000 9000ccdd 2a80
0 0000400c 00000000 f 00 00000001 1 80001000 9000ccdd 2a80
3 00000000 00000000 0 02 00000000 1 80001000 9000ccdd 2a80
2 00008400 11111111 f 00 00000000 1 80001000 9000ccdd 2a80
2 00004800 deadbeef f 00 00000000 1 80001000 9000ccdd 2a80
0 00004400 00000000 f 00 80001000 1 80001000 9000ccdd 2a80
1 00004400 7f000000 8 00 00000000 1 7f001000 9000ccdd 2a80
1 0000440c 00000001 f 00 00000000 1 7f001000 9000ccdd 2a80
3 00000000 00000000 0 80 00000000 0 7f001000 9000ccdd 2a80
0 00004004 00000000 f 00 000000b3 0 7f001000 9000ccdd 2a80
1 0000400c 00000001 f 00 00000000 0 7f001000 9000ccdd 2a80
1 00004008 000000ff f 00 00000000 0 7f001000 9000ccdd 2a80
0 00004004 00000000 f 00 00000000 0 7f001000 9000ccdd 2a80

//--- periph_subsys.f
+incdir+common
common/periph_pkg.sv
periph_demux/periph_demux.sv
logic/event_unit_regs.sv
logic/dma_cfg_regs.sv
logic/periph_subsys_top.sv
verif/periph_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f periph_subsys.f \
  --top-module periph_subsys_tb -o periph_subsys_sim

out=$(./obj_dir/periph_subsys_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi
